// File: vlog.f
+incdir+src
+incdir+bench
src/backend_pkg.sv
src/mem_stage.sv
src/dmem_arbiter.sv
src/data_mem.sv
src/write_back_stage.sv
src/reg_file.sv
src/backend_top.sv
bench/backend_tb.sv

// File: run_sim.sh
#!/bin/bash

rm -rf obj_dir sim.log

verilator --binary --timing -f vlog.f --top-module backend_tb -o backend_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/backend_sim > sim.log 2>&1
cat sim.log

grep -qF '** FAIL **' sim.log && { echo "Simulation failed"; exit 1; }
grep -qF '** PASS **' sim.log && exit 0 || { echo "No verdict found in sim.log"; exit 1; }

// File: bench/backend_model.svh
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

function automatic bit op_is_load(backend_pkg::mem_op_e op);
    return op inside {backend_pkg::mem_lb, backend_pkg::mem_lh, backend_pkg::mem_lw,
                      backend_pkg::mem_lbu, backend_pkg::mem_lhu};
endfunction

function automatic bit op_is_store(backend_pkg::mem_op_e op);
    return op inside {backend_pkg::mem_sb, backend_pkg::mem_sh, backend_pkg::mem_sw};
endfunction

// 0 byte, 1 half, 2 word
function automatic logic [1:0] op_size(backend_pkg::mem_op_e op);
    case (op)
        backend_pkg::mem_lh, backend_pkg::mem_lhu, backend_pkg::mem_sh: return 2'd1;
        backend_pkg::mem_lw, backend_pkg::mem_sw:                       return 2'd2;
        default:                                                        return 2'd0;
    endcase
endfunction

// Addressed lane of the word, then sign or zero extension
function automatic logic [31:0] load_extend(backend_pkg::mem_op_e op, logic [31:0] word,
                                            logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*off +: 8];
    h = word[16*off[1] +: 16];   // Halfword ignores bit 0
    case (op)
        backend_pkg::mem_lb:  return {{24{b[7]}}, b};
        backend_pkg::mem_lbu: return {24'd0, b};
        backend_pkg::mem_lh:  return {{16{h[15]}}, h};
        backend_pkg::mem_lhu: return {16'd0, h};
        default:              return word;
    endcase
endfunction

// Store data copied into every lane of its size
function automatic logic [31:0] store_lanes(backend_pkg::mem_op_e op, logic [31:0] data);
    case (op)
        backend_pkg::mem_sb: return {4{data[7:0]}};
        backend_pkg::mem_sh: return {2{data[15:0]}};
        default:             return data;
    endcase
endfunction

function automatic logic [31:0] store_merge(logic [31:0] old, backend_pkg::mem_op_e op,
                                            logic [31:0] data, logic [1:0] off);
    logic [31:0] w;
    w = old;
    case (op)
        backend_pkg::mem_sb: w[8*off +: 8] = data[7:0];
        backend_pkg::mem_sh: w[16*off[1] +: 16] = data[15:0];
        backend_pkg::mem_sw: w = data;
        default: ;
    endcase
    return w;
endfunction

// Retire record for one instruction, given the memory word before the access
function automatic backend_pkg::trace_t expect_trace(backend_pkg::ex_mem_t ex,
                                                     logic [31:0] mem_word);
    backend_pkg::trace_t t;
    logic [31:0]         ld;
    logic                wr;
    ld         = load_extend(ex.op, mem_word, ex.alu_result[1:0]);
    wr         = ex.rd_we && (ex.rd != 5'd0);
    t          = '0;
    t.valid    = 1'b1;
    t.pc       = ex.pc;
    t.instr    = ex.instr;
    t.rd       = ex.rd;
    t.is_load  = op_is_load(ex.op);
    t.is_store = op_is_store(ex.op);
    t.mem_size = op_size(ex.op);
    t.mem_addr = ex.alu_result;
    t.rd_data  = wr ? (t.is_load ? ld : ex.alu_result) : 32'd0;
    t.mem_data = t.is_load ? ld : (t.is_store ? store_lanes(ex.op, ex.store_data) : 32'd0);
    return t;
endfunction

`endif

// File: bench/backend_tb.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module backend_tb;

    localparam int n_alu       = 40;
    localparam int n_rounds    = 12;   // One store and five loads each
    localparam int n_burst     = 16;
    localparam int n_instr     = n_alu + 6 * n_rounds + n_burst;
    localparam int cycle_limit = 200 + 4 * n_instr;

    localparam backend_pkg::mem_op_e store_ops [3] = '{backend_pkg::mem_sb,
        backend_pkg::mem_sh, backend_pkg::mem_sw};
    localparam backend_pkg::mem_op_e load_ops [5] = '{backend_pkg::mem_lb, backend_pkg::mem_lh,
        backend_pkg::mem_lw, backend_pkg::mem_lbu, backend_pkg::mem_lhu};

    logic                        clk = 1'b0;
    logic                        reset;
    logic                        ex_valid;
    backend_pkg::ex_mem_t        ex;
    logic [`BACKEND_REG_AW-1:0]  rs1_addr;
    logic [`BACKEND_REG_AW-1:0]  rs2_addr;
    logic [`BACKEND_XLEN-1:0]    rs1_data;
    logic [`BACKEND_XLEN-1:0]    rs2_data;
    logic                        host_req;
    logic                        host_we;
    logic [`BACKEND_DMEM_AW-1:0] host_addr;
    logic [`BACKEND_XLEN-1:0]    host_wdata;
    logic                        host_ack;
    logic [`BACKEND_XLEN-1:0]    host_rdata;
    backend_pkg::trace_t         trace_rec;

    logic [31:0]         shadow_mem [0:`BACKEND_DMEM_WORDS-1];
    logic [31:0]         shadow_regs [0:`BACKEND_NREGS-1];
    backend_pkg::trace_t exp_q [$];
    int                  due_q [$];    // Cycle each record should retire in
    int                  cycles = 0;
    logic [31:0]         pc_next;
    logic                burst_done;

    `include "backend_model.svh"

    backend_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .ex_valid_i   (ex_valid),
        .ex_i         (ex),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .host_req_i   (host_req),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_ack_o   (host_ack),
        .host_rdata_o (host_rdata),
        .trace_o      (trace_rec)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, what, got, want));
        end
    endtask

    function automatic backend_pkg::ex_mem_t make_instr(backend_pkg::mem_op_e op,
                                                        logic [7:0] word);
        backend_pkg::ex_mem_t e;
        e.pc         = '0;
        e.instr      = $urandom;
        e.store_data = $urandom;
        e.op         = op;
        if (op == backend_pkg::mem_none) begin
            e.alu_result = $urandom;
            e.rd         = 5'($urandom_range(0, 31));   // x0 included
            e.rd_we      = ($urandom_range(0, 3) != 0);
        end else begin
            e.alu_result = {22'd0, word, 2'($urandom_range(0, 3))};
            e.rd         = 5'($urandom_range(1, 31));
            e.rd_we      = op_is_load(op);
        end
        return e;
    endfunction

    // Model first, then drive for one cycle
    task automatic issue(input backend_pkg::ex_mem_t e_in);
        backend_pkg::ex_mem_t e;
        backend_pkg::trace_t  t;
        logic [7:0]           word;
        e       = e_in;
        e.pc    = pc_next;
        pc_next = pc_next + 32'd4;
        word    = e.alu_result[`BACKEND_DMEM_AW+1:2];
        t       = expect_trace(e, shadow_mem[word]);
        if (op_is_store(e.op)) begin
            shadow_mem[word] = store_merge(shadow_mem[word], e.op, e.store_data,
                                           e.alu_result[1:0]);
        end
        if (e.rd_we && (e.rd != 5'd0)) begin
            shadow_regs[e.rd] = t.rd_data;
        end
        exp_q.push_back(t);
        due_q.push_back(cycles + 2);
        ex       = e;
        ex_valid = 1'b1;
        @(posedge clk);
        #2;
        ex_valid = 1'b0;
    endtask

    task automatic host_access(input logic we, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        do @(negedge clk); while (!host_ack);
        rdata = host_rdata;
        @(posedge clk);
        #2;
        host_req = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        @(posedge clk);
        #2;
    endtask

    task automatic compare_regs();
        for (int r = 0; r < 16; r++) begin
            rs1_addr = 5'(r);
            rs2_addr = 5'(r + 16);
            @(negedge clk);
            expect_equal($sformatf("x%0d", r), rs1_data, shadow_regs[5'(r)]);
            expect_equal($sformatf("x%0d", r + 16), rs2_data, shadow_regs[5'(r + 16)]);
            @(posedge clk);
            #2;
        end
    endtask

    //////////////////////////////////////////////////
    // Timeout and trace scoreboard
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
        end
    end

    always @(negedge clk) begin : compare_trace
        backend_pkg::trace_t want;
        int                  due;
        if (reset && trace_rec.valid) begin
            if (exp_q.size() == 0) begin
                abort_run("A trace record retired with no instruction outstanding");
            end else begin
                want = exp_q.pop_front();
                due  = due_q.pop_front();
                expect_equal("trace cycle", cycles, due);   // Two edges after input
                expect_equal("trace pc", trace_rec.pc, want.pc);
                expect_equal("trace instr", trace_rec.instr, want.instr);
                expect_equal("trace rd", trace_rec.rd, want.rd);
                expect_equal("trace rd_data", trace_rec.rd_data, want.rd_data);
                expect_equal("trace is_load", trace_rec.is_load, want.is_load);
                expect_equal("trace is_store", trace_rec.is_store, want.is_store);
                expect_equal("trace mem_size", trace_rec.mem_size, want.mem_size);
                expect_equal("trace mem_addr", trace_rec.mem_addr, want.mem_addr);
                expect_equal("trace mem_data", trace_rec.mem_data, want.mem_data);
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin : main
        backend_pkg::ex_mem_t st;
        backend_pkg::ex_mem_t ld;
        logic [7:0]           word;
        logic [31:0]          wval;
        logic [31:0]          rd_word;
        void'($urandom(32'he692));
        reset      = 1'b0;
        ex_valid   = 1'b0;
        ex         = '0;
        rs1_addr   = '0;
        rs2_addr   = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        pc_next    = 32'h0000_1000;
        for (int r = 0; r < `BACKEND_NREGS; r++) begin
            shadow_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b1;

        // Reset state
        for (int i = 0; i < 8; i++) begin
            rs1_addr = 5'($urandom_range(0, 31));
            rs2_addr = 5'($urandom_range(0, 31));
            @(negedge clk);
            expect_equal("trace valid after reset", trace_rec.valid, 1'b0);
            expect_equal("host ack after reset", host_ack, 1'b0);
            expect_equal("rs1 after reset", rs1_data, 32'd0);
            expect_equal("rs2 after reset", rs2_data, 32'd0);
            @(posedge clk);
            #2;
        end

        // Host fills words 0..15 while idle, then reads them back
        for (int w = 0; w < 16; w++) begin
            wval            = $urandom;
            shadow_mem[w]   = wval;
            host_access(1'b1, 8'(w), wval, rd_word);
        end
        for (int w = 0; w < 16; w++) begin
            host_access(1'b0, 8'(w), 32'd0, rd_word);
            expect_equal($sformatf("host readback word %0d", w), rd_word, shadow_mem[w]);
        end

        // Back-to-back ALU instructions
        for (int i = 0; i < n_alu; i++) begin
            issue(make_instr(backend_pkg::mem_none, 8'd0));
        end
        drain();
        compare_regs();

        // Store, then all five loads at the same byte address
        for (int i = 0; i < n_rounds; i++) begin
            word = 8'($urandom_range(0, 15));
            st   = make_instr(store_ops[2'($urandom_range(0, 2))], word);
            issue(st);
            for (int k = 0; k < 5; k++) begin
                ld            = make_instr(load_ops[3'(k)], word);
                ld.alu_result = st.alu_result;
                issue(ld);
            end
        end
        drain();
        compare_regs();

        // Host read of word 2 held off by a memory burst
        burst_done = 1'b0;
        fork
            begin
                host_access(1'b0, 8'd2, 32'd0, rd_word);
                expect_equal("host ack after burst", burst_done, 1'b1);
            end
            begin
                issue(make_instr(backend_pkg::mem_sb, 8'd2));
                for (int i = 1; i < n_burst; i++) begin
                    if (i % 2 == 1) begin
                        issue(make_instr(load_ops[3'($urandom_range(0, 4))],
                                         8'($urandom_range(0, 3))));
                    end else begin
                        issue(make_instr(store_ops[2'($urandom_range(0, 2))],
                                         8'($urandom_range(0, 3))));
                    end
                end
                burst_done = 1'b1;
            end
        join
        expect_equal("host read after burst", rd_word, shadow_mem[2]);
        drain();
        compare_regs();

        $display("** PASS **");
        $finish;
    end

endmodule

// File: src/backend_top.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module backend_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ex_valid_i,
    input  backend_pkg::ex_mem_t        ex_i,
    input  logic [`BACKEND_REG_AW-1:0]  rs1_addr_i,
    input  logic [`BACKEND_REG_AW-1:0]  rs2_addr_i,
    output logic [`BACKEND_XLEN-1:0]    rs1_data_o,
    output logic [`BACKEND_XLEN-1:0]    rs2_data_o,
    input  logic                        host_req_i,
    input  logic                        host_we_i,
    input  logic [`BACKEND_DMEM_AW-1:0] host_addr_i,
    input  logic [`BACKEND_XLEN-1:0]    host_wdata_i,
    output logic                        host_ack_o,
    output logic [`BACKEND_XLEN-1:0]    host_rdata_o,
    output backend_pkg::trace_t         trace_o
);

    backend_pkg::dmem_req_t     stage_req;
    backend_pkg::dmem_req_t     mem_req;
    backend_pkg::mem_wb_t       mem_wb;
    logic [`BACKEND_XLEN-1:0]   mem_rdata;
    logic                       rf_we;
    logic [`BACKEND_REG_AW-1:0] rf_waddr;
    logic [`BACKEND_XLEN-1:0]   rf_wdata;

    //////////////////////////////////////////////////
    // Memory side
    //////////////////////////////////////////////////

    mem_stage u_mem_stage (
        .clk        (clk),
        .reset      (reset),
        .ex_valid_i (ex_valid_i),
        .ex_i       (ex_i),
        .dmem_req_o (stage_req),
        .mem_wb_o   (mem_wb)
    );

    dmem_arbiter u_dmem_arbiter (
        .clk          (clk),
        .reset        (reset),
        .stage_req_i  (stage_req),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .mem_req_o    (mem_req),
        .mem_rdata_i  (mem_rdata),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o)
    );

    data_mem u_data_mem (
        .clk     (clk),
        .req_i   (mem_req),
        .rdata_o (mem_rdata)
    );

    //////////////////////////////////////////////////
    // Write-back side
    //////////////////////////////////////////////////

    write_back_stage u_write_back_stage (
        .clk         (clk),
        .reset       (reset),
        .mem_wb_i    (mem_wb),
        .mem_rdata_i (mem_rdata),   // Straight from the memory register
        .rf_we_o     (rf_we),
        .rf_waddr_o  (rf_waddr),
        .rf_wdata_o  (rf_wdata),
        .trace_o     (trace_o)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .raddr_a_i (rs1_addr_i),
        .raddr_b_i (rs2_addr_i),
        .rdata_a_o (rs1_data_o),
        .rdata_b_o (rs2_data_o)
    );

endmodule

// File: src/reg_file.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       we_i,
    input  logic [`BACKEND_REG_AW-1:0] waddr_i,
    input  logic [`BACKEND_XLEN-1:0]   wdata_i,
    input  logic [`BACKEND_REG_AW-1:0] raddr_a_i,
    input  logic [`BACKEND_REG_AW-1:0] raddr_b_i,
    output logic [`BACKEND_XLEN-1:0]   rdata_a_o,
    output logic [`BACKEND_XLEN-1:0]   rdata_b_o
);

    logic [`BACKEND_XLEN-1:0] regs [0:`BACKEND_NREGS-1];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `BACKEND_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;   // x0 never written
        end
    end

    // Combinational reads, x0 forced to zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// File: src/write_back_stage.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module write_back_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  backend_pkg::mem_wb_t       mem_wb_i,
    input  logic [`BACKEND_XLEN-1:0]   mem_rdata_i,
    output logic                       rf_we_o,
    output logic [`BACKEND_REG_AW-1:0] rf_waddr_o,
    output logic [`BACKEND_XLEN-1:0]   rf_wdata_o,
    output backend_pkg::trace_t        trace_o
);

    logic [7:0]               ld_byte;
    logic [15:0]              ld_half;
    logic [`BACKEND_XLEN-1:0] ld_value;
    logic [`BACKEND_XLEN-1:0] result;
    logic                     is_load;
    logic                     is_store;
    logic [1:0]               mem_size;

    assign ld_byte = mem_rdata_i[{mem_wb_i.byte_off, 3'b000} +: 8];
    assign ld_half = mem_wb_i.byte_off[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

    // Load extension and access size
    always_comb begin
        ld_value = '0;
        is_load  = 1'b0;
        is_store = 1'b0;
        mem_size = 2'd0;
        case (mem_wb_i.op)
            backend_pkg::mem_lb:  begin ld_value = {{24{ld_byte[7]}}, ld_byte};   is_load = 1'b1; end
            backend_pkg::mem_lbu: begin ld_value = {24'd0, ld_byte};              is_load = 1'b1; end
            backend_pkg::mem_lh:  begin ld_value = {{16{ld_half[15]}}, ld_half};
                                        is_load = 1'b1; mem_size = 2'd1; end
            backend_pkg::mem_lhu: begin ld_value = {16'd0, ld_half};
                                        is_load = 1'b1; mem_size = 2'd1; end
            backend_pkg::mem_lw:  begin ld_value = mem_rdata_i; is_load = 1'b1; mem_size = 2'd2; end
            backend_pkg::mem_sb:  is_store = 1'b1;
            backend_pkg::mem_sh:  begin is_store = 1'b1; mem_size = 2'd1; end
            backend_pkg::mem_sw:  begin is_store = 1'b1; mem_size = 2'd2; end
            default: ;   // ALU only
        endcase
    end

    assign result     = is_load ? ld_value : mem_wb_i.alu_result;
    assign rf_we_o    = mem_wb_i.valid && mem_wb_i.rd_we && (mem_wb_i.rd != '0);
    assign rf_waddr_o = mem_wb_i.rd;
    assign rf_wdata_o = result;

    //////////////////////////////////////////////////
    // Retire trace
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            trace_o <= '0;
        end else begin
            trace_o.valid <= mem_wb_i.valid;
            if (mem_wb_i.valid) begin
                trace_o.pc       <= mem_wb_i.pc;
                trace_o.instr    <= mem_wb_i.instr;
                trace_o.rd       <= mem_wb_i.rd;
                trace_o.rd_data  <= rf_we_o ? result : '0;   // Zero when nothing retires to rd
                trace_o.is_load  <= is_load;
                trace_o.is_store <= is_store;
                trace_o.mem_size <= mem_size;
                trace_o.mem_addr <= mem_wb_i.alu_result;
                trace_o.mem_data <= is_load  ? ld_value :
                                    is_store ? mem_wb_i.store_data : '0;
            end
        end
    end

endmodule

// File: src/data_mem.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module data_mem (
    input  logic                     clk,
    input  backend_pkg::dmem_req_t   req_i,
    output logic [`BACKEND_XLEN-1:0] rdata_o
);

    logic [`BACKEND_XLEN-1:0] mem [0:`BACKEND_DMEM_WORDS-1];
    logic [`BACKEND_XLEN-1:0] rdata_q;

    // Byte lane writes
    always_ff @(posedge clk) begin
        if (req_i.req && req_i.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req_i.be[i]) begin
                    mem[req_i.addr][8*i +: 8] <= req_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // Read before write on the same word
    always_ff @(posedge clk) begin
        if (req_i.req) begin
            rdata_q <= mem[req_i.addr];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: src/dmem_arbiter.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module dmem_arbiter (
    input  logic                        clk,
    input  logic                        reset,
    input  backend_pkg::dmem_req_t      stage_req_i,
    input  logic                        host_req_i,
    input  logic                        host_we_i,
    input  logic [`BACKEND_DMEM_AW-1:0] host_addr_i,
    input  logic [`BACKEND_XLEN-1:0]    host_wdata_i,
    output backend_pkg::dmem_req_t      mem_req_o,
    input  logic [`BACKEND_XLEN-1:0]    mem_rdata_i,
    output logic                        host_ack_o,
    output logic [`BACKEND_XLEN-1:0]    host_rdata_o
);

    backend_pkg::owner_e owner_d;
    backend_pkg::owner_e owner_q;
    logic                host_grant;

    // Host may not be granted again while its ack is out
    assign host_grant = host_req_i && !stage_req_i.req &&
                        (owner_q != backend_pkg::owner_host);

    // Pipeline always wins
    always_comb begin
        mem_req_o = '0;
        owner_d   = backend_pkg::owner_none;
        if (stage_req_i.req) begin
            mem_req_o = stage_req_i;
            owner_d   = backend_pkg::owner_stage;
        end else if (host_grant) begin
            mem_req_o.req   = 1'b1;
            mem_req_o.we    = host_we_i;
            mem_req_o.be    = 4'b1111;   // Host works on whole words
            mem_req_o.addr  = host_addr_i;
            mem_req_o.wdata = host_wdata_i;
            owner_d         = backend_pkg::owner_host;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            owner_q <= backend_pkg::owner_none;
        end else begin
            owner_q <= owner_d;
        end
    end

    // Read data lands in the cycle after the grant
    assign host_ack_o   = (owner_q == backend_pkg::owner_host);
    assign host_rdata_o = host_ack_o ? mem_rdata_i : '0;

endmodule

// File: src/mem_stage.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ex_valid_i,
    input  backend_pkg::ex_mem_t   ex_i,
    output backend_pkg::dmem_req_t dmem_req_o,
    output backend_pkg::mem_wb_t   mem_wb_o
);

    logic [1:0]               byte_off;
    logic [`BACKEND_XLEN-1:0] store_word;
    logic                     is_store;
    backend_pkg::mem_wb_t     wb_q;

    assign byte_off = ex_i.alu_result[1:0];

    //////////////////////////////////////////////////
    // Request decode
    //////////////////////////////////////////////////

    always_comb begin
        dmem_req_o = '0;
        store_word = ex_i.store_data;
        is_store   = 1'b0;
        case (ex_i.op)
            backend_pkg::mem_sb: begin
                is_store      = 1'b1;
                store_word    = {4{ex_i.store_data[7:0]}};
                dmem_req_o.be = 4'b0001 << byte_off;
            end
            backend_pkg::mem_sh: begin
                is_store      = 1'b1;
                store_word    = {2{ex_i.store_data[15:0]}};
                dmem_req_o.be = byte_off[1] ? 4'b1100 : 4'b0011;   // Bit 0 ignored
            end
            backend_pkg::mem_sw: begin
                is_store      = 1'b1;
                dmem_req_o.be = 4'b1111;
            end
            default: begin
                dmem_req_o.be = 4'b0000;   // Loads read the whole word
            end
        endcase

        dmem_req_o.req   = ex_valid_i && (ex_i.op != backend_pkg::mem_none);
        dmem_req_o.we    = is_store;
        dmem_req_o.addr  = ex_i.alu_result[`BACKEND_DMEM_AW+1:2];
        dmem_req_o.wdata = store_word;
    end

    //////////////////////////////////////////////////
    // MEM/WB pipeline register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wb_q <= '0;
        end else begin
            wb_q.valid <= ex_valid_i;   // Bubble when no strobe
            if (ex_valid_i) begin
                wb_q.pc         <= ex_i.pc;
                wb_q.instr      <= ex_i.instr;
                wb_q.alu_result <= ex_i.alu_result;
                wb_q.op         <= ex_i.op;
                wb_q.rd         <= ex_i.rd;
                wb_q.rd_we      <= ex_i.rd_we;
                wb_q.byte_off   <= byte_off;
                wb_q.store_data <= store_word;
            end
        end
    end

    assign mem_wb_o = wb_q;

endmodule

// File: src/backend_pkg.sv
`include "backend_consts.svh"

package backend_pkg;

    // Memory operation carried down from execute
    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lh   = 4'd2,
        mem_lw   = 4'd3,
        mem_lbu  = 4'd4,
        mem_lhu  = 4'd5,
        mem_sb   = 4'd6,
        mem_sh   = 4'd7,
        mem_sw   = 4'd8
    } mem_op_e;

    // Who owns the data memory read port this cycle
    typedef enum logic [1:0] {
        owner_none  = 2'd0,
        owner_stage = 2'd1,
        owner_host  = 2'd2
    } owner_e;

    typedef struct packed {
        logic [`BACKEND_XLEN-1:0]   pc;
        logic [`BACKEND_XLEN-1:0]   instr;
        logic [`BACKEND_XLEN-1:0]   alu_result;   // Also the memory byte address
        logic [`BACKEND_XLEN-1:0]   store_data;
        mem_op_e                    op;
        logic [`BACKEND_REG_AW-1:0] rd;
        logic                       rd_we;
    } ex_mem_t;

    typedef struct packed {
        logic                       valid;
        logic [`BACKEND_XLEN-1:0]   pc;
        logic [`BACKEND_XLEN-1:0]   instr;
        logic [`BACKEND_XLEN-1:0]   alu_result;
        mem_op_e                    op;
        logic [`BACKEND_REG_AW-1:0] rd;
        logic                       rd_we;
        logic [1:0]                 byte_off;
        logic [`BACKEND_XLEN-1:0]   store_data;   // Lane aligned copy
    } mem_wb_t;

    typedef struct packed {
        logic                        req;
        logic                        we;
        logic [3:0]                  be;
        logic [`BACKEND_DMEM_AW-1:0] addr;         // Word address
        logic [`BACKEND_XLEN-1:0]    wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                       valid;
        logic [`BACKEND_XLEN-1:0]   pc;
        logic [`BACKEND_XLEN-1:0]   instr;
        logic [`BACKEND_REG_AW-1:0] rd;
        logic [`BACKEND_XLEN-1:0]   rd_data;
        logic                       is_load;
        logic                       is_store;
        logic [1:0]                 mem_size;     // 0 byte, 1 half, 2 word
        logic [`BACKEND_XLEN-1:0]   mem_addr;
        logic [`BACKEND_XLEN-1:0]   mem_data;
    } trace_t;

endpackage

// File: src/backend_consts.svh
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

//////////////////////////////////////////////////
// Datapath and register file sizes
//////////////////////////////////////////////////

`define BACKEND_XLEN        32   // Integer datapath width
`define BACKEND_NREGS       32   // Architectural registers x0..x31
`define BACKEND_REG_AW      5    // Register index width

//////////////////////////////////////////////////
// Data memory geometry, word addressed
//////////////////////////////////////////////////

`define BACKEND_DMEM_WORDS  256
`define BACKEND_DMEM_AW     8    // log2 of the depth

`endif
